/* src/npu_pkg.sv */
package npu_pkg;

  ////////////////////////////////////////////////////////////
  // datapath widths and counts
  ////////////////////////////////////////////////////////////

  localparam int DATA_W         = 16;  // samples, weights, offsets and config words
  localparam int ACC_W          = 48;  // partial sums flowing down the chain
  localparam int NUM_PE         = 8;   // processing elements in the chain
  localparam int PE_IDX_W       = 3;   // enough bits to name one pe
  localparam int OFFSET_FRAC    = 7;   // fraction bits the offset is shifted up by
  localparam int WBUF_DEPTH     = 64;  // words per weight buffer
  localparam int OBUF_DEPTH     = 16;  // words in the offset buffer
  localparam int ACC_FIFO_DEPTH = 16;  // chain results parked for a later pass

  ////////////////////////////////////////////////////////////
  // scalar types
  ////////////////////////////////////////////////////////////

  typedef logic signed [DATA_W-1:0] data_t;  // fixed point sample or weight
  typedef logic signed [ACC_W-1:0]  acc_t;   // wide accumulator word
  typedef logic [PE_IDX_W-1:0]      pe_idx_t;  // pe or buffer index

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  // configuration port as it comes off the config FIFO
  typedef struct packed {
    data_t   data;      // word to store
    pe_idx_t wbuf_sel;  // which weight buffer takes the word
    logic    wbuf_we;   // store into the selected weight buffer
    logic    obuf_we;   // store into the offset buffer
  } cfg_bus_t;

  // strobes from the scheduler FSM
  typedef struct packed {
    logic    pe_write_en;        // latch the input bus into one pe
    pe_idx_t pe_sel;             // pe that takes the sample
    logic    acc_fifo_write_en;  // push the last pe sum
    logic    acc_fifo_read_en;   // feed the FIFO head into pe 0 and pop it
    logic    offset_read_en;     // step the offset buffer on
    pe_idx_t out_sel;            // pe sum driven onto the output
  } sched_t;

  typedef data_t [NUM_PE-1:0] pe_vec_data_t;  // one sample per pe
  typedef acc_t  [NUM_PE-1:0] pe_vec_acc_t;   // one partial sum per pe

endpackage

/* src/npu_circ_buf.sv */
`timescale 1ns/100ps

module npu_circ_buf #(
  parameter int DEPTH = 64
) (
  input  logic           CLK,
  input  logic           npu_rst,
  input  logic           read_en,
  input  logic           write_en,
  input  npu_pkg::data_t din,
  output npu_pkg::data_t dout
);

  import npu_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);        // address bits
  localparam int CNT_W = $clog2(DEPTH + 1);    // count has to reach DEPTH itself
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);  // last slot before wrap
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);      // every slot written

  data_t             mem [DEPTH];  // config words in write order
  logic [PTR_W-1:0]  wr_ptr;       // next slot a config write lands in
  logic [PTR_W-1:0]  rd_ptr;       // slot currently on the output
  logic [CNT_W-1:0]  count;        // how many slots hold real data
  logic              rd_wrap;      // read pointer is on the last written slot

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (write_en) begin
      mem[wr_ptr] <= din;          // words are replayed in the order they arrive
    end
  end

  ////////////////////////////////////////////////////////////
  // pointers
  ////////////////////////////////////////////////////////////

  assign rd_wrap = (CNT_W'(rd_ptr) + 1'b1) == count;  // loop length is the written count

  always_ff @(posedge CLK) begin
    if (npu_rst) begin
      wr_ptr <= '0;                // a reset also throws away the loaded words
      rd_ptr <= '0;
      count  <= '0;
    end else if (write_en) begin
      wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
      if (count != CNT_FULL) begin
        count <= count + 1'b1;     // saturates once the buffer is full
      end
    end else if (read_en && (count != '0)) begin
      rd_ptr <= rd_wrap ? '0 : rd_ptr + 1'b1;  // back to the first word after the last
    end
  end

  assign dout = (count == '0) ? '0 : mem[rd_ptr];  // an empty buffer reads as zero

endmodule

/* src/npu_input_decode.sv */
`timescale 1ns/100ps

module npu_input_decode (
  input  logic                  CLK,
  input  logic                  npu_rst,
  input  npu_pkg::cfg_bus_t     cfg,
  input  logic                  pe_write_en,
  input  npu_pkg::pe_idx_t      pe_sel,
  input  npu_pkg::data_t        input_data,
  output npu_pkg::pe_vec_data_t pe_data,
  output logic [npu_pkg::NUM_PE-1:0] wbuf_we,
  output npu_pkg::data_t        cfg_data
);

  import npu_pkg::*;

  ////////////////////////////////////////////////////////////
  // sample load decode
  ////////////////////////////////////////////////////////////

  logic [NUM_PE-1:0] pe_load;     // one-hot load strobe per pe
  pe_vec_data_t      sample_q;    // the stored sample of every pe

  always_comb begin
    pe_load = '0;                 // nothing loads unless the scheduler asks
    if (pe_write_en) begin
      pe_load[pe_sel] = 1'b1;     // only the addressed pe sees the strobe
    end
  end

  // each pe keeps its sample until the scheduler writes a new one
  always_ff @(posedge CLK) begin
    if (npu_rst) begin
      sample_q <= '0;             // all pes start from a zero sample
    end else begin
      for (int i = 0; i < NUM_PE; i++) begin
        if (pe_load[i]) begin
          sample_q[i] <= input_data;  // sample is live for the next compute edge
        end
      end
    end
  end

  assign pe_data = sample_q;

  ////////////////////////////////////////////////////////////
  // weight buffer write decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    wbuf_we = '0;                 // idle config cycles write nowhere
    if (cfg.wbuf_we) begin
      wbuf_we[cfg.wbuf_sel] = 1'b1;  // replaces the eight separate write strobes
    end
  end

  assign cfg_data = cfg.data;     // shared write data for every config store

endmodule

/* src/npu_pe_array.sv */
`timescale 1ns/100ps

module npu_pe_array (
  input  logic                       CLK,
  input  logic                       npu_rst,
  input  logic                       compute,
  input  npu_pkg::pe_vec_data_t      pe_data,
  input  logic [npu_pkg::NUM_PE-1:0] wbuf_we,
  input  npu_pkg::data_t             cfg_data,
  input  npu_pkg::acc_t              chain_in,
  output npu_pkg::pe_vec_acc_t       pe_acc
);

  import npu_pkg::*;

  ////////////////////////////////////////////////////////////
  // one lane per pe
  ////////////////////////////////////////////////////////////

  for (genvar g = 0; g < NUM_PE; g++) begin : g_lane

    data_t                      weight;  // current weight from this lane's buffer
    data_t                      sample;  // stored sample seen as a signed word
    logic signed [2*DATA_W-1:0] prod;    // full precision product
    acc_t                       carry;   // partial sum coming into this lane
    acc_t                       acc_nxt; // value the lane takes on a compute edge
    acc_t                       acc_q;   // registered partial sum

    // the weight buffer steps on every compute cycle so the weights cycle through
    npu_circ_buf #(
      .DEPTH    (WBUF_DEPTH)
    ) u_wbuf (
      .CLK      (CLK),
      .npu_rst  (npu_rst),
      .read_en  (compute),
      .write_en (wbuf_we[g]),
      .din      (cfg_data),
      .dout     (weight)
    );

    assign sample = pe_data[g];        // this lane's stored sample

    if (g == 0) begin : g_head
      assign carry = chain_in;         // first lane takes the offset or the parked sum
    end else begin : g_link
      assign carry = pe_acc[g-1];      // later lanes take the sum of the lane before
    end

    assign prod    = (2*DATA_W)'(sample) * (2*DATA_W)'(weight);  // both operands signed
    assign acc_nxt = carry + acc_t'(prod);  // product sign extends into the wide sum

    always_ff @(posedge CLK) begin
      if (npu_rst) begin
        acc_q <= '0;
      end else if (compute) begin
        acc_q <= acc_nxt;              // sums hold whenever compute is low
      end
    end

    assign pe_acc[g] = acc_q;

  end

  // with compute high every lane moves at once so a new sum enters lane 0
  // while older sums are still rippling toward lane 7

endmodule

/* src/npu_result_stage.sv */
`timescale 1ns/100ps

module npu_result_stage (
  input  logic                 CLK,
  input  logic                 npu_rst,
  input  npu_pkg::data_t       cfg_data,
  input  logic                 obuf_we,
  input  logic                 offset_read_en,
  input  logic                 acc_fifo_write_en,
  input  logic                 acc_fifo_read_en,
  input  npu_pkg::pe_idx_t     out_sel,
  input  npu_pkg::pe_vec_acc_t pe_acc,
  output npu_pkg::acc_t        chain_in,
  output npu_pkg::acc_t        pe_dout
);

  import npu_pkg::*;

  localparam int FIFO_PTR_W = $clog2(ACC_FIFO_DEPTH);  // pointers wrap on their own

  ////////////////////////////////////////////////////////////
  // offset buffer
  ////////////////////////////////////////////////////////////

  data_t offset;        // bias word for the current neuron
  acc_t  offset_term;   // bias lined up with the product fraction bits

  npu_circ_buf #(
    .DEPTH    (OBUF_DEPTH)
  ) u_obuf (
    .CLK      (CLK),
    .npu_rst  (npu_rst),
    .read_en  (offset_read_en),
    .write_en (obuf_we),
    .din      (cfg_data),
    .dout     (offset)
  );

  assign offset_term = {{(ACC_W - DATA_W - OFFSET_FRAC){offset[DATA_W-1]}},
                        offset, {OFFSET_FRAC{1'b0}}};  // sign extend then shift by 7

  ////////////////////////////////////////////////////////////
  // accumulator FIFO
  ////////////////////////////////////////////////////////////

  acc_t                  fifo_mem [ACC_FIFO_DEPTH];  // parked chain results
  logic [FIFO_PTR_W-1:0] fifo_head;                  // oldest entry
  logic [FIFO_PTR_W-1:0] fifo_tail;                  // next free slot

  always_ff @(posedge CLK) begin
    if (acc_fifo_write_en) begin
      fifo_mem[fifo_tail] <= pe_acc[NUM_PE-1];  // only the end of the chain is saved
    end
  end

  // the scheduler is trusted not to overfill or underread
  always_ff @(posedge CLK) begin
    if (npu_rst) begin
      fifo_head <= '0;
      fifo_tail <= '0;
    end else begin
      if (acc_fifo_write_en) begin
        fifo_tail <= fifo_tail + 1'b1;
      end
      if (acc_fifo_read_en) begin
        fifo_head <= fifo_head + 1'b1;  // head was already used this cycle
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // chain input and output select
  ////////////////////////////////////////////////////////////

  assign chain_in = acc_fifo_read_en ? fifo_mem[fifo_head] : offset_term;  // head shows before the pop
  assign pe_dout  = pe_acc[out_sel];  // any pe sum can be tapped

endmodule

/* src/npu_compute_unit.sv */
`timescale 1ns/100ps

module npu_compute_unit (
  input  logic              CLK,
  input  logic              npu_rst,
  input  logic              compute,
  input  npu_pkg::cfg_bus_t cfg,
  input  npu_pkg::sched_t   sched,
  input  npu_pkg::data_t    input_data,
  output npu_pkg::acc_t     pe_dout
);

  import npu_pkg::*;

  pe_vec_data_t      pe_data;   // stored samples, one per pe
  logic [NUM_PE-1:0] wbuf_we;   // one-hot weight buffer write strobe
  data_t             cfg_data;  // config word shared by every store
  acc_t              chain_in;  // carry into pe 0
  pe_vec_acc_t       pe_acc;    // registered sums of all pes

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  npu_input_decode u_decode (
    .CLK         (CLK),
    .npu_rst     (npu_rst),
    .cfg         (cfg),
    .pe_write_en (sched.pe_write_en),
    .pe_sel      (sched.pe_sel),
    .input_data  (input_data),
    .pe_data     (pe_data),
    .wbuf_we     (wbuf_we),
    .cfg_data    (cfg_data)
  );

  ////////////////////////////////////////////////////////////
  // execute
  ////////////////////////////////////////////////////////////

  npu_pe_array u_pe_array (
    .CLK      (CLK),
    .npu_rst  (npu_rst),
    .compute  (compute),
    .pe_data  (pe_data),
    .wbuf_we  (wbuf_we),
    .cfg_data (cfg_data),
    .chain_in (chain_in),
    .pe_acc   (pe_acc)
  );

  ////////////////////////////////////////////////////////////
  // result
  ////////////////////////////////////////////////////////////

  npu_result_stage u_result (
    .CLK               (CLK),
    .npu_rst           (npu_rst),
    .cfg_data          (cfg_data),
    .obuf_we           (cfg.obuf_we),           // offset writes bypass the decode stage
    .offset_read_en    (sched.offset_read_en),
    .acc_fifo_write_en (sched.acc_fifo_write_en),
    .acc_fifo_read_en  (sched.acc_fifo_read_en),
    .out_sel           (sched.out_sel),
    .pe_acc            (pe_acc),
    .chain_in          (chain_in),
    .pe_dout           (pe_dout)
  );

endmodule

/* include/tb_npu_model.svh */
`ifndef TB_NPU_MODEL_SVH
`define TB_NPU_MODEL_SVH

////////////////////////////////////////////////////////////
// reference model of the pe chain
////////////////////////////////////////////////////////////

// offset as it enters pe 0 with the fraction bits lined up
function automatic npu_pkg::acc_t scaled_offset(input npu_pkg::data_t offset);
  return npu_pkg::acc_t'(offset) <<< npu_pkg::OFFSET_FRAC;  // cast sign extends first
endfunction

// one lane product widened to the accumulator
function automatic npu_pkg::acc_t lane_product(input npu_pkg::data_t sample,
                                               input npu_pkg::data_t weight);
  return npu_pkg::acc_t'(sample) * npu_pkg::acc_t'(weight);
endfunction

// settled sum of pe last when the inputs have been steady long enough
function automatic npu_pkg::acc_t settled_sum(input npu_pkg::acc_t carry,
                                              input npu_pkg::pe_vec_data_t samples,
                                              input npu_pkg::pe_vec_data_t weights,
                                              input int last);
  npu_pkg::acc_t sum;
  sum = carry;
  for (int k = 0; k <= last; k++) begin
    sum += lane_product(npu_pkg::data_t'(samples[k]), npu_pkg::data_t'(weights[k]));
  end
  return sum;
endfunction

// one compute edge of the whole chain so a ripple can be followed lane by lane
function automatic npu_pkg::pe_vec_acc_t chain_step(input npu_pkg::pe_vec_acc_t prev,
                                                    input npu_pkg::acc_t carry,
                                                    input npu_pkg::pe_vec_data_t samples,
                                                    input npu_pkg::pe_vec_data_t weights);
  npu_pkg::pe_vec_acc_t nxt;
  npu_pkg::acc_t        lane_in;
  for (int k = 0; k < npu_pkg::NUM_PE; k++) begin
    lane_in = (k == 0) ? carry : npu_pkg::acc_t'(prev[k-1]);  // old value of the lane before
    nxt[k]  = lane_in + lane_product(npu_pkg::data_t'(samples[k]),
                                     npu_pkg::data_t'(weights[k]));
  end
  return nxt;
endfunction

`endif

/* bench/tb_npu_compute_unit.sv */
`timescale 1ns/100ps

module tb_npu_compute_unit;

  import npu_pkg::*;

  `include "tb_npu_model.svh"

  localparam int TIMEOUT_CYCLES = 400;  // comfortably longer than the whole sequence

  logic        CLK;
  logic        npu_rst;
  logic        compute;
  cfg_bus_t    cfg;
  sched_t      sched;
  data_t       input_data;
  acc_t        pe_dout;

  logic [31:0] lcg_state = 32'd62;  // generator state starting from the fixed seed
  int          cycle_cnt;           // clock edges seen so far
  int          test_errs;           // mismatches inside the current test
  int          tests_passed;
  int          tests_failed;

  pe_vec_data_t samples;       // samples of the first pass
  pe_vec_data_t samples2;      // samples of the pass fed from the FIFO
  pe_vec_data_t weights;       // one fixed weight per buffer
  data_t        offset_word;   // the single offset in the offset buffer
  acc_t         offset_term;   // offset after sign extension and shift
  pe_vec_acc_t  model_state;   // predicted register of every lane
  acc_t         pushed;        // sum parked in the accumulator FIFO
  data_t        wa;            // first weight of the two word loop
  data_t        wb;            // second weight of the two word loop
  data_t        x;             // sample held by pe 0 in the loop test

  npu_compute_unit DUT (
    .CLK        (CLK),
    .npu_rst    (npu_rst),
    .compute    (compute),
    .cfg        (cfg),
    .sched      (sched),
    .input_data (input_data),
    .pe_dout    (pe_dout)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;  // 20 ns period
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic data_t next_random_word();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;  // classic lcg constants
    return data_t'(lcg_state[31:16]);                     // upper bits are the most random
  endfunction

  task automatic next_cycle();
    @(posedge CLK);
    #2;  // inputs move just after the edge
  endtask

  task automatic apply_reset();
    npu_rst = 1'b1;
    repeat (3) next_cycle();
    npu_rst = 1'b0;
  endtask

  task automatic write_weight(input int idx, input data_t val);
    cfg.data     = val;
    cfg.wbuf_sel = pe_idx_t'(idx);
    cfg.wbuf_we  = 1'b1;
    next_cycle();
    cfg.wbuf_we  = 1'b0;
  endtask

  task automatic write_offset(input data_t val);
    cfg.data    = val;
    cfg.obuf_we = 1'b1;
    next_cycle();
    cfg.obuf_we = 1'b0;
  endtask

  task automatic load_sample(input int idx, input data_t val);
    input_data        = val;
    sched.pe_sel      = pe_idx_t'(idx);
    sched.pe_write_en = 1'b1;
    next_cycle();
    sched.pe_write_en = 1'b0;
  endtask

  task automatic show_sum(input int idx);
    sched.out_sel = pe_idx_t'(idx);
    #1;  // output mux is combinational so give it a moment
  endtask

  task automatic check_acc(input string what, input acc_t got, input acc_t exp);
    assert (got === exp) else begin
      $display("[FAIL] %0t ns %s: got %0d, expected %0d", $time, what, got, exp);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errs == 0) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d mismatches", name, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  ////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Some tests failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    npu_rst      = 1'b1;
    compute      = 1'b0;
    cfg          = '0;
    sched        = '0;
    input_data   = '0;
    test_errs    = 0;
    tests_passed = 0;
    tests_failed = 0;

    apply_reset();
    for (int k = 0; k < NUM_PE; k++) begin
      show_sum(k);
      check_acc($sformatf("reset out_sel %0d", k), pe_dout, '0);  // every lane starts at zero
    end
    finish_test("reset");

    // one weight per buffer keeps each weight fixed while compute runs
    for (int k = 0; k < NUM_PE; k++) begin
      weights[k] = next_random_word();
      write_weight(k, weights[k]);
    end
    offset_word = next_random_word();
    offset_term = scaled_offset(offset_word);
    write_offset(offset_word);
    for (int k = 0; k < NUM_PE; k++) begin
      samples[k] = next_random_word();
      load_sample(k, samples[k]);
    end
    compute = 1'b1;
    repeat (10) next_cycle();  // longer than the eight lane ripple
    compute = 1'b0;
    show_sum(NUM_PE - 1);
    check_acc("single pass pe 7", pe_dout,
              settled_sum(offset_term, samples, weights, NUM_PE - 1));
    finish_test("single pass");

    for (int k = 0; k < NUM_PE; k++) begin
      model_state[k] = settled_sum(offset_term, samples, weights, k);
      show_sum(k);
      check_acc($sformatf("partial sum pe %0d", k), pe_dout, model_state[k]);
    end
    finish_test("partial sums");

    // new samples arrive with compute low and no lane may move
    for (int k = 0; k < NUM_PE; k++) begin
      load_sample(k, next_random_word());
    end
    repeat (2) next_cycle();
    for (int k = 0; k < NUM_PE; k++) begin
      show_sum(k);
      check_acc($sformatf("gated pe %0d", k), pe_dout, model_state[k]);
    end
    finish_test("compute gating");

    pushed = model_state[NUM_PE-1];
    sched.acc_fifo_write_en = 1'b1;  // park the settled end of chain
    next_cycle();
    sched.acc_fifo_write_en = 1'b0;
    for (int k = 0; k < NUM_PE; k++) begin
      samples2[k] = next_random_word();
      load_sample(k, samples2[k]);
    end
    compute = 1'b1;
    sched.acc_fifo_read_en = 1'b1;  // only the first edge of the pass takes the FIFO head
    for (int i = 1; i <= NUM_PE + 2; i++) begin
      next_cycle();
      sched.acc_fifo_read_en = 1'b0;
      model_state = chain_step(model_state, (i == 1) ? pushed : offset_term,
                               samples2, weights);
      show_sum(NUM_PE - 1);
      check_acc($sformatf("round trip edge %0d", i), pe_dout, model_state[NUM_PE-1]);
      if (i == NUM_PE) begin
        check_acc("pushed sum reaches pe 7", pe_dout,
                  settled_sum(pushed, samples2, weights, NUM_PE - 1));
      end
    end
    compute = 1'b0;
    check_acc("offset path settled", pe_dout,
              settled_sum(offset_term, samples2, weights, NUM_PE - 1));
    finish_test("accumulator round trip");

    // a fresh reset empties every buffer so only buffer 0 holds weights
    apply_reset();
    wa = next_random_word();
    wb = next_random_word();
    x  = next_random_word();
    write_weight(0, wa);
    write_weight(0, wb);
    load_sample(0, x);
    compute = 1'b1;
    for (int i = 0; i < 6; i++) begin
      next_cycle();
      show_sum(0);
      check_acc($sformatf("loop edge %0d", i), pe_dout,
                lane_product(x, (i % 2 == 0) ? wa : wb));  // empty offset buffer adds zero
    end
    compute = 1'b0;
    finish_test("circular weights");

    $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+include
src/npu_pkg.sv
src/npu_circ_buf.sv
src/npu_input_decode.sv
src/npu_pe_array.sv
src/npu_result_stage.sv
src/npu_compute_unit.sv
bench/tb_npu_compute_unit.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_npu_compute_unit
FILELIST = files.f

.PHONY: sim clean

# the pipeline status is the status of grep, so a missing pass line fails the target
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "All tests passed"

clean:
	rm -rf obj_dir
